//--- flist.f
+incdir+.
amiv_video_pkg.sv
amiv_mem_pkg.sv
amiv_mem_if.sv
amiv_capture.sv
amiv_interlace_detect.sv
amiv_scan_out.sv
amiv_mem_ctrl.sv
amiv_top.sv
tb_amiv_assert.sv
tb_amiv.sv

//--- Bender.yml
package:
  name: amiv

export_include_dirs:
  - .

sources:
  - files:
      - amiv_video_pkg.sv
      - amiv_mem_pkg.sv
      - amiv_mem_if.sv
      - amiv_capture.sv
      - amiv_interlace_detect.sv
      - amiv_scan_out.sv
      - amiv_mem_ctrl.sv
      - amiv_top.sv
  - target: test
    files:
      - tb_amiv_assert.sv
      - tb_amiv.sv

//--- tb_amiv.sv
`include "amiv_defines.svh"

module tb_amiv import amiv_video_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MEM_WORDS = 1 << `AMIV_ADDR_W;
	localparam int FRAME_CYCLES = `AMIV_OUT_H_TOTAL * `AMIV_OUT_V_TOTAL * `AMIV_OUT_DIV;

	logic in_hs, rst_n, cap_valid, cap_line_start, cap_frame_start, cap_field;
	rgb30_t cap_data;
	rgb565_t sram_rdata, sram_wdata;
	logic out_pclk, out_hs, out_vs, sram_we_n, sram_oe_n;
	rgb888_t out_data;
	sram_addr_t sram_addr;

	rgb565_t sram_mem [MEM_WORDS]; // SRAM model.
	logic [15:0] ref_mem [MEM_WORDS]; // Expected SRAM contents.
	logic model_ilace, det_seen, exp_ilace; // Detection model and checked mode.
	int det_count;
	logic check_req, check_done; // Handshake with the compare process.
	int errors, checks;

	amiv_top i_amiv_top (.*);

	assign sram_rdata = !sram_oe_n ? sram_mem[sram_addr] : 'x; // Floats when idle.
	always @(posedge in_hs) begin
		if (!sram_we_n) begin
			sram_mem[sram_addr] <= sram_wdata;
		end
	end

	initial begin
		in_hs = 1'b0;
		forever #4 in_hs = ~in_hs; // 8 ns period.
	end

	function automatic logic [15:0] pack565(input logic [29:0] px);
		return {px[29:25], px[19:14], px[9:5]}; // Top bits of R, G, B.
	endfunction

	// Expected out_data for an output raster position.
	function automatic logic [23:0] expected_pixel(input int line, input int col);
		int r;
		int row;
		int a;
		logic [15:0] w;
		if (line < `AMIV_OUT_V_START || line >= `AMIV_OUT_V_START + `AMIV_SRC_H ||
			col < `AMIV_OUT_H_START || col >= `AMIV_OUT_H_START + 2 * `AMIV_SRC_W) begin
			return '0; // Border.
		end
		r = line - `AMIV_OUT_V_START;
		row = exp_ilace ? r : r / 2; // Progressive lines shown twice.
		a = col - `AMIV_OUT_H_START;
		w = ref_mem[row * `AMIV_SRC_W + a / 2]; // Each word for two columns.
		return {w[15:11], 3'b000, w[10:5], 2'b00, w[4:0], 3'b000};
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Interlace rule, applied at every frame start.
	task automatic detect_frame_start(input logic field);
		det_seen = det_seen || !field;
		det_count++;
		if (det_count == `AMIV_DETECT_FRAMES) begin
			model_ilace = det_seen;
			det_seen = 1'b0;
			det_count = 0;
		end
	endtask

	// One input frame, with two extra lines and three extra pixels when overrun is set.
	task automatic send_frame(input logic field, input logic overrun);
		int n_lines;
		int n_pix;
		int ln;
		int px_i;
		int row;
		logic [29:0] px;
		n_lines = `AMIV_IN_V_BLANK + `AMIV_SRC_H / 2 + (overrun ? 2 : 0);
		n_pix = `AMIV_IN_H_BLANK + `AMIV_SRC_W + (overrun ? 3 : 0);
		detect_frame_start(field);
		cap_field = field;
		cap_frame_start = 1'b1;
		for (ln = 0; ln < n_lines; ln++) begin
			cap_line_start = 1'b1; // First one rides with the frame start.
			@(negedge in_hs);
			cap_line_start = 1'b0;
			cap_frame_start = 1'b0;
			for (px_i = 0; px_i < n_pix; px_i++) begin
				px = 30'($urandom());
				cap_data = px;
				cap_valid = 1'b1;
				@(negedge in_hs);
				cap_valid = 1'b0;
				repeat (`AMIV_OUT_DIV - 1) @(negedge in_hs);
				if (px_i >= `AMIV_IN_H_BLANK && px_i < `AMIV_IN_H_BLANK + `AMIV_SRC_W &&
					ln >= `AMIV_IN_V_BLANK && ln < `AMIV_IN_V_BLANK + `AMIV_SRC_H / 2) begin
					row = model_ilace ? 2 * (ln - `AMIV_IN_V_BLANK) + field :
						ln - `AMIV_IN_V_BLANK;
					ref_mem[row * `AMIV_SRC_W + px_i - `AMIV_IN_H_BLANK] = pack565(px);
				end
			end
		end
		repeat (2 * `AMIV_OUT_DIV) @(negedge in_hs); // Last write drains.
	endtask

	// Compare one whole output frame, starting at the next frame start.
	task automatic check_frame(input int num, input string name);
		int waited;
		int err_mark;
		err_mark = errors;
		exp_ilace = model_ilace;
		check_done = 1'b0;
		check_req = 1'b1;
		waited = 0;
		while (!check_done) begin
			@(negedge in_hs);
			waited++;
			if (waited > 3 * FRAME_CYCLES) begin
				$display("Timeout: no output frame could be checked in test %0d", num);
				$display("ERRORS FOUND");
				$finish;
			end
		end
		$display("Test %0d %s: %0d errors", num, name, errors - err_mark);
	endtask

	// Raster position counted in slots from the first slot after reset.
	initial begin
		int col_pos;
		int line_pos;
		int slot_clk; // Clocks since the last slot start.
		logic locked;
		logic prev_pclk;
		logic checking;
		locked = 1'b0;
		checking = 1'b0;
		col_pos = 0;
		line_pos = 0;
		slot_clk = 0;
		forever begin
			@(negedge in_hs);
			if (!rst_n) begin
				locked = 1'b0;
				prev_pclk = 1'b0;
			end else if (out_pclk && !prev_pclk) begin // New slot.
				if (locked) begin
					check_value("out_pclk period", slot_clk, `AMIV_OUT_DIV - 1);
					slot_clk = 0;
					col_pos++;
					if (col_pos == `AMIV_OUT_H_TOTAL) begin
						col_pos = 0;
						line_pos = (line_pos + 1) % `AMIV_OUT_V_TOTAL;
					end
				end else begin
					locked = 1'b1; // Raster starts at line 0, column 0.
					col_pos = 0;
					line_pos = 0;
					slot_clk = 1; // First rise comes one clock into the slot.
				end
				check_value("out_hs", out_hs, col_pos >= `AMIV_OUT_HFP &&
					col_pos < `AMIV_OUT_HFP + `AMIV_OUT_HSW);
				check_value("out_vs", out_vs, line_pos >= `AMIV_OUT_VBP &&
					line_pos < `AMIV_OUT_VBP + `AMIV_OUT_VSW);
				if (check_req && line_pos == 0 && col_pos == 0) begin
					check_req = 1'b0;
					checking = 1'b1;
				end
				if (checking) begin
					check_value($sformatf("out_data line %0d col %0d", line_pos, col_pos),
						out_data, expected_pixel(line_pos, col_pos));
					if (line_pos == `AMIV_OUT_V_TOTAL - 1 &&
						col_pos == `AMIV_OUT_H_TOTAL - 1) begin
						checking = 1'b0;
						check_done = 1'b1; // Whole frame seen.
					end
				end
			end else if (locked) begin
				slot_clk++;
				check_value("out_pclk", out_pclk, slot_clk < `AMIV_OUT_DIV / 2); // High half.
			end
			prev_pclk = out_pclk;
		end
	end

	initial begin
		int i;
		int n;
		int asrt;
		void'($urandom(32'h7d91d3b9));
		rst_n = 1'b0;
		cap_valid = 1'b0;
		cap_line_start = 1'b0;
		cap_frame_start = 1'b0;
		cap_field = 1'b1;
		cap_data = '0;
		{errors, checks, det_count} = '0;
		{check_req, check_done, model_ilace, exp_ilace, det_seen} = '0;
		for (i = 0; i < MEM_WORDS; i++) begin
			sram_mem[i] = '0; // Black frame before any capture.
			ref_mem[i] = '0;
		end
		repeat (10) @(negedge in_hs);
		check_value("reset out_pclk", out_pclk, 0);
		check_value("reset out_hs", out_hs, 0);
		check_value("reset out_vs", out_vs, 0);
		check_value("reset out_data", out_data, 0);
		check_value("reset strobes", {sram_we_n, sram_oe_n}, 2'b11);
		rst_n = 1'b1;

		check_frame(1, "idle output and sync positions");
		send_frame(1'b1, 1'b0);
		check_frame(2, "progressive line doubling");
		send_frame(1'b1, 1'b1);
		check_frame(3, "input blanking window");
		n = 0;
		while ((n < `AMIV_DETECT_FRAMES || !model_ilace) && n < 3 * `AMIV_DETECT_FRAMES) begin
			send_frame(logic'(n % 2), 1'b0); // Fields alternate, low first.
			n++;
		end
		check_frame(4, "interlaced field order");
		n = 0;
		while ((n < `AMIV_DETECT_FRAMES || model_ilace) && n < 3 * `AMIV_DETECT_FRAMES) begin
			send_frame(1'b1, 1'b0);
			n++;
		end
		check_frame(5, "return to progressive");

		asrt = i_amiv_top.i_mem_ctrl.i_mem_assert.fail_cnt;
		$display("Checks %0d, errors %0d, assertion failures %0d", checks, errors, asrt);
		if (errors == 0 && asrt == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- tb_amiv_assert.sv
module tb_amiv_assert import amiv_mem_pkg::*; (
	input logic in_hs,
	input logic rst_n,
	input mem_state_e state,
	input mem_op_e op,
	input logic wr_req,
	input logic wr_ack,
	input logic rd_req,
	input logic rd_ack,
	input logic sram_we_n,
	input logic sram_oe_n
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned fail_cnt = 0; // Read by the testbench at the end.

	// Requester lets go only after the acknowledge.
	wr_req_held: assert property (@(posedge in_hs) disable iff (!rst_n)
		$fell(wr_req) |-> $past(wr_ack)) else begin
		$error("write req dropped before ack");
		fail_cnt++;
	end
	rd_req_held: assert property (@(posedge in_hs) disable iff (!rst_n)
		$fell(rd_req) |-> $past(rd_ack)) else begin
		$error("read req dropped before ack");
		fail_cnt++;
	end

	// Ack only answers a live request.
	wr_ack_req: assert property (@(posedge in_hs) disable iff (!rst_n)
		$rose(wr_ack) |-> wr_req) else begin
		$error("write ack without req");
		fail_cnt++;
	end
	rd_ack_req: assert property (@(posedge in_hs) disable iff (!rst_n)
		$rose(rd_ack) |-> rd_req) else begin
		$error("read ack without req");
		fail_cnt++;
	end

	strobe_excl: assert property (@(posedge in_hs) disable iff (!rst_n)
		sram_we_n || sram_oe_n) else begin
		$error("sram_we_n and sram_oe_n low together");
		fail_cnt++;
	end

	// Capture must space its pixels past a whole write.
	wr_no_overlap: assert property (@(posedge in_hs) disable iff (!rst_n)
		$rose(wr_req) |-> !wr_ack && !(state != IDLE && op == OP_WRITE)) else begin
		$error("write req rose while a write was pending");
		fail_cnt++;
	end

endmodule

bind amiv_mem_ctrl tb_amiv_assert i_mem_assert (
	.in_hs (in_hs),
	.rst_n (rst_n),
	.state (state),
	.op (op),
	.wr_req (wr.req),
	.wr_ack (wr.ack),
	.rd_req (rd.req),
	.rd_ack (rd.ack),
	.sram_we_n (sram_we_n),
	.sram_oe_n (sram_oe_n)
);

//--- amiv_top.sv
module amiv_top import amiv_video_pkg::*; (
	input logic in_hs,
	input logic rst_n,
	input logic cap_valid,
	input logic cap_line_start,
	input logic cap_frame_start,
	input logic cap_field,
	input rgb30_t cap_data,
	input rgb565_t sram_rdata,
	output logic out_pclk,
	output logic out_hs,
	output logic out_vs,
	output rgb888_t out_data,
	output sram_addr_t sram_addr,
	output logic sram_we_n,
	output logic sram_oe_n,
	output rgb565_t sram_wdata
);

	logic interlaced; // Detected input mode.

	amiv_mem_if wr_bus (); // Capture to controller.
	amiv_mem_if rd_bus (); // Scan-out to controller.

	amiv_capture i_capture (
		.in_hs (in_hs),
		.rst_n (rst_n),
		.cap_valid (cap_valid),
		.cap_line_start (cap_line_start),
		.cap_frame_start (cap_frame_start),
		.cap_field (cap_field),
		.cap_data (cap_data),
		.interlaced (interlaced),
		.wr (wr_bus.wr_requester)
	);

	amiv_interlace_detect i_interlace_detect (
		.in_hs (in_hs),
		.rst_n (rst_n),
		.cap_frame_start (cap_frame_start),
		.cap_field (cap_field),
		.interlaced (interlaced)
	);

	amiv_scan_out i_scan_out (
		.in_hs (in_hs),
		.rst_n (rst_n),
		.interlaced (interlaced),
		.rd (rd_bus.rd_requester),
		.out_pclk (out_pclk),
		.out_hs (out_hs),
		.out_vs (out_vs),
		.out_data (out_data)
	);

	amiv_mem_ctrl i_mem_ctrl (
		.in_hs (in_hs),
		.rst_n (rst_n),
		.sram_rdata (sram_rdata),
		.wr (wr_bus.wr_controller),
		.rd (rd_bus.rd_controller),
		.sram_addr (sram_addr),
		.sram_we_n (sram_we_n),
		.sram_oe_n (sram_oe_n),
		.sram_wdata (sram_wdata)
	);

endmodule

//--- amiv_mem_ctrl.sv
module amiv_mem_ctrl import amiv_video_pkg::*, amiv_mem_pkg::*; (
	input logic in_hs,
	input logic rst_n,
	input rgb565_t sram_rdata,
	amiv_mem_if.wr_controller wr,
	amiv_mem_if.rd_controller rd,
	output sram_addr_t sram_addr,
	output logic sram_we_n,
	output logic sram_oe_n,
	output rgb565_t sram_wdata
);

	mem_state_e state;
	mem_op_e op; // Requester being served.
	logic rd_go; // Start a read.
	logic wr_go; // Start a write.
	logic op_req; // Req of the served requester.

	// Read first, scan-out cannot wait.
	assign rd_go = state == IDLE && rd.req;
	assign wr_go = state == IDLE && !rd.req && wr.req;
	assign op_req = (op == OP_READ) ? rd.req : wr.req;

	always_ff @(posedge in_hs) begin
		if (!rst_n) begin
			state <= IDLE;
			op <= OP_READ;
			sram_we_n <= 1'b1;
			sram_oe_n <= 1'b1;
			wr.ack <= 1'b0;
			rd.ack <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (rd_go) begin
						op <= OP_READ;
						sram_oe_n <= 1'b0;
						state <= ACCESS;
					end else if (wr_go) begin
						op <= OP_WRITE;
						sram_we_n <= 1'b0;
						state <= ACCESS;
					end
				end
				ACCESS: begin
					sram_we_n <= 1'b1; // One strobe cycle only.
					sram_oe_n <= 1'b1;
					state <= SAMPLE;
				end
				SAMPLE: begin
					if (op == OP_READ) begin
						rd.ack <= 1'b1;
					end else begin
						wr.ack <= 1'b1;
					end
					state <= ACK;
				end
				ACK: begin
					if (!op_req) begin // Requester has let go.
						rd.ack <= 1'b0;
						wr.ack <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Address and write word set up with the strobe.
	always_ff @(posedge in_hs) begin
		if (rd_go) begin
			sram_addr <= rd.addr;
		end else if (wr_go) begin
			sram_addr <= wr.addr;
			sram_wdata <= wr.data;
		end
		if (state == ACCESS && op == OP_READ) begin
			rd.data <= sram_rdata; // Taken while oe_n is low.
		end
	end

endmodule

//--- amiv_scan_out.sv
`include "amiv_defines.svh"

module amiv_scan_out import amiv_video_pkg::*; (
	input logic in_hs,
	input logic rst_n,
	input logic interlaced,
	amiv_mem_if.rd_requester rd,
	output logic out_pclk,
	output logic out_hs,
	output logic out_vs,
	output rgb888_t out_data
);

	typedef logic [$clog2(`AMIV_OUT_DIV)-1:0] slot_t;
	typedef logic [$clog2(`AMIV_OUT_H_TOTAL)-1:0] hcnt_t;
	typedef logic [$clog2(`AMIV_OUT_V_TOTAL)-1:0] vcnt_t;

	slot_t slot; // Clock within slot.
	slot_t slot_n;
	hcnt_t col; // Output column.
	hcnt_t col_n;
	hcnt_t fetch_rel; // Active column fetched two slots ahead.
	vcnt_t line_cnt;
	vcnt_t line_n;
	logic slot_end;
	logic line_end;
	logic frame_end;
	logic line_act; // Current line in active window.
	logic line_act_n;
	logic col_act_n;
	logic fetch_n; // Issue a read as the next slot starts.
	logic ilace; // Mode of this output frame.
	logic second_pass; // Stored line shown again.
	sram_addr_t rd_cnt; // Next word to read.
	rgb565_t fetch_buf; // Word for the next column pair.

	// Zero-filled low bits.
	function automatic rgb888_t expand(rgb565_t p);
		return '{r: {p.r, 3'b000}, g: {p.g, 2'b00}, b: {p.b, 3'b000}};
	endfunction

	assign slot_end = slot == `AMIV_OUT_DIV - 1;
	assign line_end = slot_end && col == `AMIV_OUT_H_TOTAL - 1;
	assign frame_end = line_end && line_cnt == `AMIV_OUT_V_TOTAL - 1;

	assign slot_n = slot_end ? '0 : slot + 1'b1;
	assign col_n = line_end ? '0 : (slot_end ? col + 1'b1 : col);
	assign line_n = frame_end ? '0 : (line_end ? line_cnt + 1'b1 : line_cnt);

	assign line_act = (line_cnt >= `AMIV_OUT_V_START) &&
		(line_cnt < `AMIV_OUT_V_START + `AMIV_SRC_H);
	assign line_act_n = (line_n >= `AMIV_OUT_V_START) &&
		(line_n < `AMIV_OUT_V_START + `AMIV_SRC_H);
	assign col_act_n = (col_n >= `AMIV_OUT_H_START) &&
		(col_n < `AMIV_OUT_H_START + 2 * `AMIV_SRC_W);

	// Same parity as the displayed column, so bit 0 marks odd columns too.
	assign fetch_rel = hcnt_t'(col_n + 2 - `AMIV_OUT_H_START);
	assign fetch_n = slot_end && line_act_n && !fetch_rel[0] &&
		(col_n + 2 >= `AMIV_OUT_H_START) && (fetch_rel < 2 * `AMIV_SRC_W);

	always_ff @(posedge in_hs) begin
		if (!rst_n) begin
			slot <= '0;
			col <= '0;
			line_cnt <= '0;
			out_pclk <= 1'b0;
			out_hs <= 1'b0;
			out_vs <= 1'b0;
			out_data <= '0;
			ilace <= 1'b0;
			second_pass <= 1'b0;
			rd_cnt <= '0;
			rd.req <= 1'b0;
		end else begin
			slot <= slot_n;
			col <= col_n;
			line_cnt <= line_n;
			out_pclk <= slot_n < `AMIV_OUT_DIV / 2; // High in first half.
			if (slot_end) begin // Outputs move at slot start.
				out_hs <= (col_n >= `AMIV_OUT_HFP) &&
					(col_n < `AMIV_OUT_HFP + `AMIV_OUT_HSW);
				out_vs <= (line_n >= `AMIV_OUT_VBP) &&
					(line_n < `AMIV_OUT_VBP + `AMIV_OUT_VSW);
				if (!(line_act_n && col_act_n)) begin
					out_data <= '0; // Black border.
				end else if (!fetch_rel[0]) begin
					out_data <= expand(fetch_buf); // Odd column repeats it.
				end
			end
			if (frame_end) begin
				ilace <= interlaced; // Mode fixed for the whole frame.
				second_pass <= 1'b0;
				rd_cnt <= '0;
			end else if (line_end && line_act && !ilace) begin
				second_pass <= !second_pass;
				if (!second_pass) begin
					rd_cnt <= rd_cnt - sram_addr_t'(`AMIV_SRC_W); // Same row again.
				end
			end else if (fetch_n) begin
				rd_cnt <= rd_cnt + 1'b1;
			end
			if (fetch_n) begin
				rd.req <= 1'b1;
			end else if (rd.ack) begin
				rd.req <= 1'b0;
			end
		end
	end

	always_ff @(posedge in_hs) begin
		if (fetch_n) begin
			rd.addr <= rd_cnt;
		end
		if (rd.req && rd.ack) begin
			fetch_buf <= rd.data; // Valid while ack is high.
		end
	end

endmodule

//--- amiv_interlace_detect.sv
`include "amiv_defines.svh"

module amiv_interlace_detect (
	input logic in_hs,
	input logic rst_n,
	input logic cap_frame_start,
	input logic cap_field,
	output logic interlaced
);

	logic [$clog2(`AMIV_DETECT_FRAMES)-1:0] frame_cnt; // Frame starts in window.
	logic seen; // Field low at some frame start.
	logic seen_now;
	logic window_end;

	assign seen_now = seen || !cap_field; // Includes this frame start.
	assign window_end = frame_cnt == `AMIV_DETECT_FRAMES - 1;

	always_ff @(posedge in_hs) begin
		if (!rst_n) begin
			frame_cnt <= '0;
			seen <= 1'b0;
			interlaced <= 1'b0; // Progressive until shown otherwise.
		end else if (cap_frame_start) begin
			if (window_end) begin
				interlaced <= seen_now; // Decision for next window.
				seen <= 1'b0;
				frame_cnt <= '0;
			end else begin
				seen <= seen_now;
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

endmodule

//--- amiv_capture.sv
`include "amiv_defines.svh"

module amiv_capture import amiv_video_pkg::*; (
	input logic in_hs,
	input logic rst_n,
	input logic cap_valid,
	input logic cap_line_start,
	input logic cap_frame_start,
	input logic cap_field,
	input rgb30_t cap_data,
	input logic interlaced,
	amiv_mem_if.wr_requester wr
);

	typedef logic [7:0] cnt_t; // Input counters, saturating.

	cnt_t pix_cnt; // Valid pixels since line start.
	cnt_t line_cnt; // Line starts since frame start.
	cnt_t pix_now;
	cnt_t line_now;
	cnt_t col;
	cnt_t wline;
	logic in_window;
	logic take;
	sram_addr_t row;
	sram_addr_t addr_next;
	rgb565_t data_next;

	// Counter values seen by a pixel in this cycle.
	// A strobe in the same cycle as cap_valid applies to that pixel.
	always_comb begin
		pix_now = cap_line_start ? '0 : pix_cnt;
		if (cap_frame_start) begin
			line_now = '0; // Frame start wins over a line start.
		end else if (cap_line_start && line_cnt != '1) begin
			line_now = line_cnt + 1'b1;
		end else begin
			line_now = line_cnt;
		end
	end

	assign in_window = (pix_now >= `AMIV_IN_H_BLANK) &&
		(pix_now < `AMIV_IN_H_BLANK + `AMIV_SRC_W) &&
		(line_now >= `AMIV_IN_V_BLANK) &&
		(line_now < `AMIV_IN_V_BLANK + `AMIV_SRC_H / 2);
	assign take = cap_valid && in_window;

	assign col = pix_now - cnt_t'(`AMIV_IN_H_BLANK); // Column in window.
	assign wline = line_now - cnt_t'(`AMIV_IN_V_BLANK);

	// Interlaced fields go to alternate rows, field high is the odd row.
	assign row = interlaced ? sram_addr_t'({wline, cap_field}) : sram_addr_t'(wline);
	assign addr_next = sram_addr_t'(row * `AMIV_SRC_W + col);

	// Top bits of each channel.
	assign data_next = '{r: cap_data.r[9:5], g: cap_data.g[9:4], b: cap_data.b[9:5]};

	always_ff @(posedge in_hs) begin
		if (!rst_n) begin
			pix_cnt <= '0;
			line_cnt <= '0;
			wr.req <= 1'b0;
		end else begin
			if (cap_valid && pix_now != '1) begin
				pix_cnt <= pix_now + 1'b1;
			end else begin
				pix_cnt <= pix_now;
			end
			line_cnt <= line_now;
			if (take) begin
				wr.req <= 1'b1; // Spacing keeps ack low here.
			end else if (wr.ack) begin
				wr.req <= 1'b0; // Phase two done.
			end
		end
	end

	// Held stable while req is high.
	always_ff @(posedge in_hs) begin
		if (take) begin
			wr.addr <= addr_next;
			wr.data <= data_next;
		end
	end

endmodule

//--- amiv_mem_if.sv
interface amiv_mem_if import amiv_video_pkg::*; ();

	logic req; // Four-phase request.
	logic ack; // Four-phase acknowledge.
	sram_addr_t addr;
	rgb565_t data; // Write word or returned read word.

	// Write side, requester owns the data.
	modport wr_requester (
		output req, addr, data,
		input ack
	);
	modport wr_controller (
		input req, addr, data,
		output ack
	);

	// Read side, controller returns the data.
	modport rd_requester (
		output req, addr,
		input ack, data
	);
	modport rd_controller (
		input req, addr,
		output ack, data
	);

endinterface

//--- amiv_mem_pkg.sv
package amiv_mem_pkg;

	// SRAM access sequence.
	typedef enum logic [1:0] {
		IDLE, // Waiting for a request.
		ACCESS, // Strobe low.
		SAMPLE, // Strobe high, read word held.
		ACK // Waiting for req to drop.
	} mem_state_e;

	// Access kind being served.
	typedef enum logic {
		OP_READ,
		OP_WRITE
	} mem_op_e;

endpackage

//--- amiv_video_pkg.sv
`include "amiv_defines.svh"

package amiv_video_pkg;

	// Input pixel, red in the top bits.
	typedef struct packed {
		logic [9:0] r;
		logic [9:0] g;
		logic [9:0] b;
	} rgb30_t;

	// Stored SRAM word.
	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb888_t;

	typedef logic [`AMIV_ADDR_W-1:0] sram_addr_t; // Word address.

endpackage

//--- amiv_defines.svh
`ifndef AMIV_DEFINES_SVH
`define AMIV_DEFINES_SVH

// Stored frame in the SRAM.
`define AMIV_SRC_W 16 // Pixels per stored line.
`define AMIV_SRC_H 12 // Lines per stored frame, both fields.

// Input blanking offsets, in pixels and lines.
`define AMIV_IN_H_BLANK 3
`define AMIV_IN_V_BLANK 2

// Output raster, counted in pixel slots and lines.
`define AMIV_OUT_HFP 2
`define AMIV_OUT_HSW 2
`define AMIV_OUT_H_START 6 // After hsync, two slots ahead for the first fetch.
`define AMIV_OUT_H_TOTAL (`AMIV_OUT_H_START + 2 * `AMIV_SRC_W + 2)
`define AMIV_OUT_VBP 1
`define AMIV_OUT_VSW 2
`define AMIV_OUT_V_START 4
`define AMIV_OUT_V_TOTAL (`AMIV_OUT_V_START + `AMIV_SRC_H + 2)

`define AMIV_OUT_DIV 16 // Clocks per output slot, even.
`define AMIV_DETECT_FRAMES 4 // Frame starts per interlace decision.
`define AMIV_ADDR_W 8 // SRAM word address.

`endif
